// File: include/mouse_settings.svh
`ifndef MOUSE_SETTINGS_SVH
`define MOUSE_SETTINGS_SVH

// Screen size in pixels
`define MOUSE_SCREEN_W 1024
`define MOUSE_SCREEN_H 768

// Game playfield edges
`define MOUSE_GAME_MIN_X 361
`define MOUSE_GAME_MAX_X 661
`define MOUSE_GAME_MIN_Y 367
`define MOUSE_GAME_MAX_Y 667

// Cursor sprite is square
`define MOUSE_CURSOR_SIZE 16

// Upper cursor limits for the full menu screen
`define MOUSE_MENU_MAX_X (`MOUSE_SCREEN_W - 1 - `MOUSE_CURSOR_SIZE)
`define MOUSE_MENU_MAX_Y (`MOUSE_SCREEN_H - 1 - `MOUSE_CURSOR_SIZE)

// Cursor position after reset
`define MOUSE_RESET_X 512
`define MOUSE_RESET_Y 384

`endif

// File: hdl/mouse_pkg.sv
package mouse_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Application mode
    ////////////////////////////////////////////////////////////////////////////

    // Codes other than menu and game keep the current limits
    typedef enum logic [2:0] {
        MODE_MENU = 3'd0,
        MODE_GAME = 3'd1
    } mouse_mode_t;

    ////////////////////////////////////////////////////////////////////////////
    // Coordinates and movement
    ////////////////////////////////////////////////////////////////////////////

    // Unsigned pixel coordinate
    typedef logic [11:0] pos_t;

    // Signed movement of one PS/2 packet
    typedef logic signed [8:0] delta_t;

endpackage

// File: hdl/mouse_packet_decoder.sv
`timescale 1ns/100ps

module mouse_packet_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             byte_data,
    input  logic                   byte_valid,
    output logic                   move_valid,
    output mouse_pkg::delta_t      move_dx,
    output mouse_pkg::delta_t      move_dy,
    output logic [2:0]             buttons
);

    ////////////////////////////////////////////////////////////////////////////
    // Byte sequencing
    ////////////////////////////////////////////////////////////////////////////

    // Position of the next byte within the packet
    logic [1:0]        byte_idx;
    logic              accept;
    logic              last_byte;

    // Status and X bytes held until the Y byte arrives
    logic [7:0]        status_byte;
    logic [7:0]        x_byte;

    mouse_pkg::delta_t dx_nxt;
    mouse_pkg::delta_t dy_nxt;

    // Status byte always has bit 3 set, anything else is dropped to resync
    assign accept    = byte_valid && ((byte_idx != 2'd0) || byte_data[3]);
    assign last_byte = accept && (byte_idx == 2'd2);

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_idx <= 2'd0;
        end else if (accept) begin
            if (byte_idx == 2'd2) begin
                byte_idx <= 2'd0;
            end else begin
                byte_idx <= byte_idx + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && (byte_idx == 2'd0)) begin
            status_byte <= byte_data;
        end
        if (accept && (byte_idx == 2'd1)) begin
            x_byte <= byte_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Delta assembly
    ////////////////////////////////////////////////////////////////////////////

    // Sign bits live in the status byte
    // overflow forces the axis to zero
    always_comb begin
        if (status_byte[6]) begin
            dx_nxt = '0;
        end else begin
            dx_nxt = {status_byte[4], x_byte};
        end

        // Y byte is still on the input in this cycle
        if (status_byte[7]) begin
            dy_nxt = '0;
        end else begin
            dy_nxt = {status_byte[5], byte_data};
        end
    end

    // Report registers with a single cycle strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            move_valid <= 1'b0;
            buttons    <= 3'd0;
        end else begin
            move_valid <= last_byte;
            if (last_byte) begin
                buttons <= status_byte[2:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (last_byte) begin
            move_dx <= dx_nxt;
            move_dy <= dy_nxt;
        end
    end

endmodule

// File: hdl/mouse_constrainer.sv
`timescale 1ns/100ps

`include "mouse_settings.svh"

module mouse_constrainer (
    input  logic                   clk,
    input  logic                   rst,
    input  mouse_pkg::mouse_mode_t mouse_mode,
    output mouse_pkg::pos_t        value,
    output logic                   set_max_x,
    output logic                   set_max_y,
    output logic                   set_min_x,
    output logic                   set_min_y
);

    // Limit values for both regions
    localparam mouse_pkg::pos_t GAME_MAX_X = 12'(`MOUSE_GAME_MAX_X - `MOUSE_CURSOR_SIZE);
    localparam mouse_pkg::pos_t GAME_MAX_Y = 12'(`MOUSE_GAME_MAX_Y - `MOUSE_CURSOR_SIZE);
    localparam mouse_pkg::pos_t GAME_MIN_X = 12'(`MOUSE_GAME_MIN_X);
    localparam mouse_pkg::pos_t GAME_MIN_Y = 12'(`MOUSE_GAME_MIN_Y);
    localparam mouse_pkg::pos_t MENU_MAX_X = 12'(`MOUSE_MENU_MAX_X);
    localparam mouse_pkg::pos_t MENU_MAX_Y = 12'(`MOUSE_MENU_MAX_Y);

    typedef enum logic {
        ST_IDLE,
        ST_LOAD
    } state_t;

    state_t                 state;
    logic [1:0]             step;
    mouse_pkg::mouse_mode_t last_mode;
    mouse_pkg::mouse_mode_t load_mode;
    logic                   start;
    logic                   active;
    logic                   in_game;
    mouse_pkg::pos_t        value_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // Load sequencing
    ////////////////////////////////////////////////////////////////////////////

    // Only a real change to menu or game triggers a reload
    always_comb begin
        start = (state == ST_IDLE)
             && ((mouse_mode == mouse_pkg::MODE_MENU) || (mouse_mode == mouse_pkg::MODE_GAME))
             && (mouse_mode != last_mode);
        active    = start || (state == ST_LOAD);
        load_mode = (state == ST_IDLE) ? mouse_mode : last_mode;
        in_game   = (load_mode == mouse_pkg::MODE_GAME);
    end

    // Step 0 goes out on the start edge itself
    always_comb begin
        case (step)
            2'd0:    value_nxt = in_game ? GAME_MAX_X : MENU_MAX_X;
            2'd1:    value_nxt = in_game ? GAME_MAX_Y : MENU_MAX_Y;
            2'd2:    value_nxt = in_game ? GAME_MIN_X : '0;
            default: value_nxt = in_game ? GAME_MIN_Y : '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            step      <= 2'd0;
            last_mode <= mouse_pkg::MODE_MENU;
            set_max_x <= 1'b0;
            set_max_y <= 1'b0;
            set_min_x <= 1'b0;
            set_min_y <= 1'b0;
        end else begin
            set_max_x <= active && (step == 2'd0);
            set_max_y <= active && (step == 2'd1);
            set_min_x <= active && (step == 2'd2);
            set_min_y <= active && (step == 2'd3);
            if (start) begin
                state     <= ST_LOAD;
                step      <= 2'd1;
                last_mode <= mouse_mode;
            end else if (state == ST_LOAD) begin
                // Wraps back to zero after min_y
                step <= step + 2'd1;
                if (step == 2'd3) begin
                    state <= ST_IDLE;
                end
            end
        end
    end

    // Bus value qualified by the strobes
    always_ff @(posedge clk) begin
        value <= value_nxt;
    end

endmodule

// File: hdl/mouse_position_tracker.sv
`timescale 1ns/100ps

`include "mouse_settings.svh"

module mouse_position_tracker (
    input  logic              clk,
    input  logic              rst,
    input  mouse_pkg::pos_t   value,
    input  logic              set_max_x,
    input  logic              set_max_y,
    input  logic              set_min_x,
    input  logic              set_min_y,
    input  logic              move_valid,
    input  mouse_pkg::delta_t move_dx,
    input  mouse_pkg::delta_t move_dy,
    output mouse_pkg::pos_t   cursor_x,
    output mouse_pkg::pos_t   cursor_y
);

    ////////////////////////////////////////////////////////////////////////////
    // Limit registers
    ////////////////////////////////////////////////////////////////////////////

    mouse_pkg::pos_t   max_x;
    mouse_pkg::pos_t   max_y;
    mouse_pkg::pos_t   min_x;
    mouse_pkg::pos_t   min_y;

    // Full menu range out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            max_x <= 12'(`MOUSE_MENU_MAX_X);
            max_y <= 12'(`MOUSE_MENU_MAX_Y);
            min_x <= '0;
            min_y <= '0;
        end else begin
            if (set_max_x) begin
                max_x <= value;
            end
            if (set_max_y) begin
                max_y <= value;
            end
            if (set_min_x) begin
                min_x <= value;
            end
            if (set_min_y) begin
                min_y <= value;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Integration and clamping
    ////////////////////////////////////////////////////////////////////////////

    // Saturate a widened signed coordinate into [lo, hi]
    function automatic mouse_pkg::pos_t clamp_pos(
        input logic signed [13:0] v,
        input mouse_pkg::pos_t    lo,
        input mouse_pkg::pos_t    hi
    );
        logic signed [13:0] lo_w;
        logic signed [13:0] hi_w;
        lo_w = $signed({2'b00, lo});
        hi_w = $signed({2'b00, hi});
        if (v < lo_w) begin
            return lo;
        end else if (v > hi_w) begin
            return hi;
        end else begin
            return v[11:0];
        end
    endfunction

    logic signed [13:0] dx_wide;
    logic signed [13:0] dy_wide;
    logic signed [13:0] sum_x;
    logic signed [13:0] sum_y;
    mouse_pkg::pos_t    next_x;
    mouse_pkg::pos_t    next_y;

    always_comb begin
        // Sign extend and gate by the report strobe
        dx_wide = move_valid ? {{5{move_dx[8]}}, move_dx} : 14'sd0;
        dy_wide = move_valid ? {{5{move_dy[8]}}, move_dy} : 14'sd0;

        // PS/2 Y grows upward, screen Y grows downward
        sum_x = $signed({2'b00, cursor_x}) + dx_wide;
        sum_y = $signed({2'b00, cursor_y}) - dy_wide;

        // Clamp even without movement so new limits take hold
        next_x = clamp_pos(sum_x, min_x, max_x);
        next_y = clamp_pos(sum_y, min_y, max_y);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cursor_x <= 12'(`MOUSE_RESET_X);
            cursor_y <= 12'(`MOUSE_RESET_Y);
        end else begin
            cursor_x <= next_x;
            cursor_y <= next_y;
        end
    end

endmodule

// File: hdl/mouse_cursor_top.sv
`timescale 1ns/100ps

module mouse_cursor_top (
    input  logic                   clk,
    input  logic                   rst,
    input  mouse_pkg::mouse_mode_t mouse_mode,
    input  logic [7:0]             byte_data,
    input  logic                   byte_valid,
    output mouse_pkg::pos_t        cursor_x,
    output mouse_pkg::pos_t        cursor_y,
    output logic [2:0]             buttons
);

    // Movement reports
    logic              move_valid;
    mouse_pkg::delta_t move_dx;
    mouse_pkg::delta_t move_dy;

    // Limit bus
    mouse_pkg::pos_t   value;
    logic              set_max_x;
    logic              set_max_y;
    logic              set_min_x;
    logic              set_min_y;

    mouse_packet_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .move_valid (move_valid),
        .move_dx    (move_dx),
        .move_dy    (move_dy),
        .buttons    (buttons)
    );

    mouse_constrainer u_constrainer (
        .clk        (clk),
        .rst        (rst),
        .mouse_mode (mouse_mode),
        .value      (value),
        .set_max_x  (set_max_x),
        .set_max_y  (set_max_y),
        .set_min_x  (set_min_x),
        .set_min_y  (set_min_y)
    );

    mouse_position_tracker u_tracker (
        .clk        (clk),
        .rst        (rst),
        .value      (value),
        .set_max_x  (set_max_x),
        .set_max_y  (set_max_y),
        .set_min_x  (set_min_x),
        .set_min_y  (set_min_y),
        .move_valid (move_valid),
        .move_dx    (move_dx),
        .move_dy    (move_dy),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y)
    );

endmodule

// File: tb/mouse_cursor_asserts.sv
`timescale 1ns/100ps

`include "mouse_settings.svh"

module mouse_cursor_asserts (
    input logic            clk,
    input logic            rst,
    input logic            move_valid,
    input logic            set_max_x,
    input logic            set_max_y,
    input logic            set_min_x,
    input logic            set_min_y,
    input mouse_pkg::pos_t cursor_x,
    input mouse_pkg::pos_t cursor_y
);

    ////////////////////////////////////////////////////////////////////////////
    // Limit bus
    ////////////////////////////////////////////////////////////////////////////

    strobe_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({set_max_x, set_max_y, set_min_x, set_min_y}))
        else $error("More than one limit strobe is high");

    // Load order is max_x, max_y, min_x, min_y
    order_max_y: assert property (@(posedge clk) disable iff (rst) set_max_x |=> set_max_y)
        else $error("set_max_x was not followed by set_max_y");
    order_min_x: assert property (@(posedge clk) disable iff (rst) set_max_y |=> set_min_x)
        else $error("set_max_y was not followed by set_min_x");
    order_min_y: assert property (@(posedge clk) disable iff (rst) set_min_x |=> set_min_y)
        else $error("set_min_x was not followed by set_min_y");

    ////////////////////////////////////////////////////////////////////////////
    // Movement and position
    ////////////////////////////////////////////////////////////////////////////

    valid_single: assert property (@(posedge clk) disable iff (rst) move_valid |=> !move_valid)
        else $error("move_valid was high for two cycles");

    on_screen: assert property (@(posedge clk) disable iff (rst)
        (cursor_x <= 12'(`MOUSE_MENU_MAX_X)) && (cursor_y <= 12'(`MOUSE_MENU_MAX_Y)))
        else $error("Cursor is beyond the screen limits");

endmodule

bind mouse_cursor_top mouse_cursor_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .move_valid (move_valid),
    .set_max_x  (set_max_x),
    .set_max_y  (set_max_y),
    .set_min_x  (set_min_x),
    .set_min_y  (set_min_y),
    .cursor_x   (cursor_x),
    .cursor_y   (cursor_y)
);

// File: tb/mouse_cursor_tb.sv
`timescale 1ns/100ps

`include "mouse_settings.svh"

module mouse_cursor_tb;

    // Upper bound on commands taken from the cases file
    localparam integer MAX_CMDS    = 400;
    localparam integer IDLE_CYCLES = 8;

    logic                   clk;
    logic                   rst;
    mouse_pkg::mouse_mode_t mouse_mode;
    logic [7:0]             byte_data;
    logic                   byte_valid;
    mouse_pkg::pos_t        cursor_x;
    mouse_pkg::pos_t        cursor_y;
    logic [2:0]             buttons;

    integer error_count;
    integer check_count;
    integer cmd_count;
    integer seed;

    mouse_cursor_top DUT (
        .clk        (clk),
        .rst        (rst),
        .mouse_mode (mouse_mode),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y),
        .buttons    (buttons)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and check tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at command %0d",
                     name, actual, expected, cmd_count);
        end
    endtask

    // One byte from the receiver, with a gap cycle after it
    task automatic drive_byte(input logic [7:0] b);
        @(negedge clk);
        byte_data  = b;
        byte_valid = 1'b1;
        @(negedge clk);
        byte_valid = 1'b0;
    endtask

    task automatic idle_cycles(input integer n);
        integer i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    // Bit 3 clear so none of these can pass for a status byte
    task automatic send_junk(input integer n);
        integer     i;
        logic [31:0] r;
        for (i = 0; i < n; i++) begin
            r = $random(seed);
            drive_byte(r[7:0] & 8'hf7);
        end
    endtask

    task automatic report_malformed(input string cmd);
        error_count++;
        $display("The stimulus file has bad arguments for %s at command %0d", cmd, cmd_count);
    endtask

    task automatic run_command(input integer fd, input string cmd, output logic ok);
        integer r;
        integer a0;
        integer a1;
        integer a2;
        ok = 1'b1;
        if (cmd == "MODE") begin
            r = $fscanf(fd, " %d", a0);
            if (r != 1 || a0 < 0 || a0 > 7) begin
                report_malformed(cmd);
                ok = 1'b0;
            end else begin
                @(negedge clk);
                mouse_mode = mouse_pkg::mouse_mode_t'(a0[2:0]);
            end
        end else if (cmd == "PKT") begin
            r = $fscanf(fd, " %h %h %h", a0, a1, a2);
            if (r != 3) begin
                report_malformed(cmd);
                ok = 1'b0;
            end else begin
                drive_byte(a0[7:0]);
                drive_byte(a1[7:0]);
                drive_byte(a2[7:0]);
            end
        end else if (cmd == "JUNK") begin
            r = $fscanf(fd, " %d", a0);
            if (r != 1 || a0 < 0 || a0 > 64) begin
                report_malformed(cmd);
                ok = 1'b0;
            end else begin
                send_junk(a0);
            end
        end else if (cmd == "EXPECT") begin
            r = $fscanf(fd, " %d %d %d", a0, a1, a2);
            if (r != 3 || a0 < 0 || a0 > `MOUSE_MENU_MAX_X || a1 < 0
                    || a1 > `MOUSE_MENU_MAX_Y || a2 < 0 || a2 > 7) begin
                report_malformed(cmd);
                ok = 1'b0;
            end else begin
                idle_cycles(IDLE_CYCLES);
                compare_value("cursor_x", {20'd0, cursor_x}, a0);
                compare_value("cursor_y", {20'd0, cursor_y}, a1);
                compare_value("buttons", {29'd0, buttons}, a2);
            end
        end else begin
            error_count++;
            $display("Unknown command %s in the stimulus file", cmd);
            ok = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        integer                fd;
        integer                r;
        logic                  done;
        logic                  ok;
        string                 cmd;
        logic [8*256-1:0]      line_rest;
        error_count = 0;
        check_count = 0;
        cmd_count   = 0;
        seed        = 32'h088e_05b4;
        rst         = 1'b1;
        mouse_mode  = mouse_pkg::MODE_MENU;
        byte_data   = 8'd0;
        byte_valid  = 1'b0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("tb/mouse_cursor_cases.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Cannot open the stimulus file tb/mouse_cursor_cases.txt");
        end else begin
            done = 1'b0;
            while (!done && cmd_count < MAX_CMDS) begin
                r = $fscanf(fd, " %s", cmd);
                if (r != 1) begin
                    done = 1'b1;
                end else if (cmd[0] == "#") begin
                    // Comment runs to the end of the line
                    r = $fgets(line_rest, fd);
                end else begin
                    cmd_count++;
                    run_command(fd, cmd, ok);
                    if (!ok) begin
                        done = 1'b1;
                    end
                end
            end
            if (!done) begin
                error_count++;
                $display("The stimulus file has more than %0d commands", MAX_CMDS);
            end
            $fclose(fd);
        end

        if (check_count == 0) begin
            error_count++;
            $display("No expected values were checked");
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tb/mouse_cursor_cases.txt
# Commands: MODE code | PKT byte0 byte1 byte2 (hex) | JUNK count | EXPECT x y buttons
# EXPECT values are decimal and are checked after the inputs have been idle
# Position after reset
EXPECT 512 384 0
# Plain moves, Y subtracts, negative signs and buttons from byte 0
PKT 09 0a 05
EXPECT 522 379 1
PKT 3a f6 fb
EXPECT 512 384 2
PKT 1c 80 20
EXPECT 384 352 4
# Menu clamps at 0 and at 1007/751
PKT 18 00 00
PKT 18 00 00
EXPECT 0 352 0
PKT 08 00 ff
PKT 08 00 ff
EXPECT 0 0 0
PKT 28 ff 00
PKT 28 ff 00
PKT 28 ff 00
PKT 28 ff 00
EXPECT 1007 751 0
# Game mode pulls the cursor inside 361..645 and 367..651
MODE 1
EXPECT 645 651 0
PKT 18 00 00
EXPECT 389 651 0
PKT 18 00 ff
PKT 08 00 ff
EXPECT 361 367 0
# Code 2 keeps the game limits
MODE 2
PKT 08 00 ff
EXPECT 361 367 0
PKT 2b 28 ec
EXPECT 401 387 3
# Back to menu without a jump, full range again
MODE 0
EXPECT 401 387 3
PKT 08 ff 00
EXPECT 656 387 0
PKT 28 00 00
PKT 28 00 00
EXPECT 656 751 0
# Junk ahead of a packet is dropped
JUNK 5
PKT 09 05 03
EXPECT 661 748 1
# Overflow bits zero their axis
PKT 48 ff 10
EXPECT 661 732 0
PKT 88 20 ff
EXPECT 693 732 0
PKT d8 33 44
EXPECT 693 732 0
JUNK 3
PKT 0c 00 00
EXPECT 693 732 4
MODE 1
EXPECT 645 651 4
MODE 0
EXPECT 645 651 4

// File: verilog.f
+incdir+include
hdl/mouse_pkg.sv
hdl/mouse_packet_decoder.sv
hdl/mouse_constrainer.sv
hdl/mouse_position_tracker.sv
hdl/mouse_cursor_top.sv
tb/mouse_cursor_asserts.sv
tb/mouse_cursor_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module mouse_cursor_tb -f verilog.f \
    -o mouse_cursor_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/mouse_cursor_sim > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1
